/* Makefile */
# Verilator build and run of the fifth power lab

BIN := obj_dir/Vtb_lab_top

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASSED'

$(BIN): project.f $(wildcard source/*.sv source/*.svh test/*.sv)
	verilator --binary --timing -Wno-fatal -f project.f \
		--top-module tb_lab_top -o Vtb_lab_top

clean:
	rm -rf obj_dir

/* project.f */
+incdir+source
source/power_pkg.sv
source/power_stage.sv
source/power_pipeline.sv
source/seven_segment_display.sv
source/lab_top.sv
test/tb_lab_top.sv

/* source/lab_top.sv */
module lab_top
(
    input  logic                  slow_clk,
    input  logic                  rst,

    // Keys and switches
    input  logic [3:0]            key,
    input  power_pkg::operand_t   sw,

    // Stage valid flags
    output logic [7:0]            led,

    // Scanned seven-segment display
    output power_pkg::segments_t  abcdefgh,
    output power_pkg::digit_sel_t digit
);

    import power_pkg::*;

    result_t         result;
    logic            result_valid;
    logic [4:0]      stage_valid;
    display_number_t shown_number;

    // ----------------------------------------------------------
    // Fifth power pipeline
    // ----------------------------------------------------------

    // key[0] starts one computation per cycle it is held
    power_pipeline i_pipeline (
        .slow_clk     (slow_clk),
        .rst          (rst),
        .start        (key[0]),
        .operand      (sw),
        .result       (result),
        .result_valid (result_valid),
        .stage_valid  (stage_valid)
    );

    // ----------------------------------------------------------
    // Display
    // ----------------------------------------------------------

    // Only the low 32 bits fit on eight digits
    assign shown_number = result[$bits(display_number_t) - 1:0];

    seven_segment_display i_7segment (
        .slow_clk (slow_clk),
        .rst      (rst),
        .number   (shown_number),
        .dots     ('0),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ----------------------------------------------------------
    // LEDs
    // ----------------------------------------------------------

    // Capture flag on led[0], last stage on led[4]
    assign led = {3'b000, result_valid, stage_valid[3:0]};

endmodule

/* source/power_cfg.svh */
`ifndef POWER_CFG_SVH
`define POWER_CFG_SVH

// ----------------------------------------------------------
// Operand side
// ----------------------------------------------------------

// Switch and operand width
`define POWER_W_OPERAND 8

// ----------------------------------------------------------
// Display side
// ----------------------------------------------------------

// Number of seven-segment digits
`define POWER_W_DIGIT 8

// Scan divider width, each digit is lit for 2**width cycles
`define POWER_W_SCAN_DIV 4

`endif

/* source/power_pipeline.sv */
`include "power_cfg.svh"

module power_pipeline
(
    input  logic                slow_clk,
    input  logic                rst,

    input  logic                start,
    input  power_pkg::operand_t operand,

    output power_pkg::result_t  result,
    output logic                result_valid,
    output logic [4:0]          stage_valid
);

    import power_pkg::*;

    localparam int w_op = `POWER_W_OPERAND;

    operand_t               cap_operand;
    logic                   cap_valid;

    logic                   valid_1;
    logic                   valid_2;
    logic                   valid_3;
    logic                   valid_4;

    operand_t               operand_1;
    operand_t               operand_2;
    operand_t               operand_3;

    logic [2 * w_op - 1:0]  partial_1;
    logic [3 * w_op - 1:0]  partial_2;
    logic [4 * w_op - 1:0]  partial_3;
    result_t                partial_4;

    logic                   have_result;

    // ----------------------------------------------------------
    // Operand capture
    // ----------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end
        else begin
            cap_valid <= start;
        end
    end

    always_ff @(posedge slow_clk) begin
        if (start) begin
            cap_operand <= operand;
        end
    end

    // ----------------------------------------------------------
    // Multiplier chain
    // ----------------------------------------------------------

    // Square
    power_stage #(.w_partial_in(w_op)) u_stage_1 (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .in_valid    (cap_valid),
        .in_operand  (cap_operand),
        .in_partial  (cap_operand),
        .out_valid   (valid_1),
        .out_operand (operand_1),
        .out_partial (partial_1)
    );

    // Cube
    power_stage #(.w_partial_in(2 * w_op)) u_stage_2 (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .in_valid    (valid_1),
        .in_operand  (operand_1),
        .in_partial  (partial_1),
        .out_valid   (valid_2),
        .out_operand (operand_2),
        .out_partial (partial_2)
    );

    // Fourth power
    power_stage #(.w_partial_in(3 * w_op)) u_stage_3 (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .in_valid    (valid_2),
        .in_operand  (operand_2),
        .in_partial  (partial_2),
        .out_valid   (valid_3),
        .out_operand (operand_3),
        .out_partial (partial_3)
    );

    // Fifth power, the operand is not needed past here
    power_stage #(.w_partial_in(4 * w_op)) u_stage_4 (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .in_valid    (valid_3),
        .in_operand  (operand_3),
        .in_partial  (partial_3),
        .out_valid   (valid_4),
        .out_operand (),
        .out_partial (partial_4)
    );

    // ----------------------------------------------------------
    // Result
    // ----------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            have_result <= 1'b0;
        end
        else if (valid_4) begin
            have_result <= 1'b1;
        end
    end

    // Zero until the first computation leaves the last stage
    assign result       = (have_result || valid_4) ? partial_4 : '0;
    assign result_valid = valid_4;
    assign stage_valid  = {valid_4, valid_3, valid_2, valid_1, cap_valid};

endmodule

/* source/power_pkg.sv */
`include "power_cfg.svh"

package power_pkg;

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------

    // Captured switch value
    typedef logic [`POWER_W_OPERAND - 1:0] operand_t;

    // Fifth power needs five operand widths
    typedef logic [5 * `POWER_W_OPERAND - 1:0] result_t;

    // ----------------------------------------------------------
    // Display
    // ----------------------------------------------------------

    // One nibble per digit
    typedef logic [4 * `POWER_W_DIGIT - 1:0] display_number_t;

    // Segments a to g and dot h, a in the top bit
    typedef logic [7:0] segments_t;

    // One-hot digit enable
    typedef logic [`POWER_W_DIGIT - 1:0] digit_sel_t;

endpackage

/* source/power_stage.sv */
`include "power_cfg.svh"

module power_stage
#(
    parameter int w_partial_in = 8
)
(
    input  logic                                       slow_clk,
    input  logic                                       rst,

    input  logic                                       in_valid,
    input  power_pkg::operand_t                        in_operand,
    input  logic [w_partial_in - 1:0]                  in_partial,

    output logic                                       out_valid,
    output power_pkg::operand_t                        out_operand,
    output logic [w_partial_in + `POWER_W_OPERAND - 1:0] out_partial
);

    localparam int w_partial_out = w_partial_in + `POWER_W_OPERAND;

    logic [w_partial_out - 1:0] product;

    // Full-width product, no truncation
    assign product = in_partial * in_operand;

    // ----------------------------------------------------------
    // Valid flag, one cycle behind the incoming one
    // ----------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end
        else begin
            out_valid <= in_valid;
        end
    end

    // ----------------------------------------------------------
    // Payload
    // ----------------------------------------------------------

    // Loads only with valid data so the value holds between operands
    always_ff @(posedge slow_clk) begin
        if (in_valid) begin
            out_operand <= in_operand;
            out_partial <= product;
        end
    end

endmodule

/* source/seven_segment_display.sv */
`include "power_cfg.svh"

module seven_segment_display
#(
    parameter int w_digit = `POWER_W_DIGIT
)
(
    input  logic                       slow_clk,
    input  logic                       rst,

    input  power_pkg::display_number_t number,
    input  logic [w_digit - 1:0]       dots,

    output power_pkg::segments_t       abcdefgh,
    output power_pkg::digit_sel_t      digit
);

    import power_pkg::*;

    logic [`POWER_W_SCAN_DIV - 1:0] scan_cnt;
    digit_sel_t                     sel;
    logic [3:0]                     nibble;
    logic                           dot;

    // Segments a to g, a in bit 6
    function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0:    hex_to_seg = 7'b1111110;
            4'h1:    hex_to_seg = 7'b0110000;
            4'h2:    hex_to_seg = 7'b1101101;
            4'h3:    hex_to_seg = 7'b1111001;
            4'h4:    hex_to_seg = 7'b0110011;
            4'h5:    hex_to_seg = 7'b1011011;
            4'h6:    hex_to_seg = 7'b1011111;
            4'h7:    hex_to_seg = 7'b1110000;
            4'h8:    hex_to_seg = 7'b1111111;
            4'h9:    hex_to_seg = 7'b1111011;
            4'ha:    hex_to_seg = 7'b1110111;
            4'hb:    hex_to_seg = 7'b0011111;
            4'hc:    hex_to_seg = 7'b1001110;
            4'hd:    hex_to_seg = 7'b0111101;
            4'he:    hex_to_seg = 7'b1001111;
            default: hex_to_seg = 7'b1000111;
        endcase
    endfunction

    // ----------------------------------------------------------
    // Scan divider and digit rotation
    // ----------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            sel      <= digit_sel_t'(1);
        end
        else begin
            scan_cnt <= scan_cnt + 1'b1;

            // Move to the next higher digit on wrap
            if (&scan_cnt) begin
                sel <= {sel[w_digit - 2:0], sel[w_digit - 1]};
            end
        end
    end

    // ----------------------------------------------------------
    // Nibble and dot of the selected digit
    // ----------------------------------------------------------

    always_comb begin
        nibble = '0;
        dot    = 1'b0;

        for (int i = 0; i < w_digit; i++) begin
            if (sel[i]) begin
                nibble = number[i * 4 +: 4];
                dot    = dots[i];
            end
        end
    end

    // ----------------------------------------------------------
    // Registered outputs
    // ----------------------------------------------------------

    // Segments and digit enable change on the same edge
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= {hex_to_seg(4'h0), 1'b0};
            digit    <= digit_sel_t'(1);
        end
        else begin
            abcdefgh <= {hex_to_seg(nibble), dot};
            digit    <= sel;
        end
    end

endmodule

/* test/tb_lab_top.sv */
`include "power_cfg.svh"

module tb_lab_top;

    timeunit 1ns;
    timeprecision 1ps;

    import power_pkg::*;

    localparam int reset_cycles = 8;
    localparam int stim_cycles  = 400;
    localparam int walk_cycles  = 7;
    localparam int hold_cycles  = 150;
    localparam int limit_cycles = reset_cycles + stim_cycles + 200;
    localparam int scan_period  = 1 << `POWER_W_SCAN_DIV;

    logic        slow_clk;
    logic        rst;
    logic [3:0]  key;
    operand_t    sw;
    logic [7:0]  led;
    segments_t   abcdefgh;
    digit_sel_t  digit;

    // Reference model state
    logic [4:0]  exp_valid;
    result_t     exp_result;
    result_t     pending[$];
    int          scan_cnt;
    int          digit_idx;
    segments_t   exp_segments;
    digit_sel_t  exp_digit;

    logic [31:0] lcg_state;
    int          errors       = 0;
    int          cycle_count  = 0;
    int          results_seen = 0;
    int          back_to_back = 0;
    string       phase;

    lab_top u_dut (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #50 slow_clk = ~slow_clk;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Operand multiplied five times on the full result width
    function automatic result_t fifth_power(input operand_t op);
        result_t acc;
        acc = result_t'(op);
        for (int n = 1; n < 5; n++) begin
            acc = acc * result_t'(op);
        end
        return acc;
    endfunction

    // Hex digit shapes with a in bit 7 and the dot off
    function automatic segments_t hex_segments(input logic [3:0] value);
        case (value)
            4'h0:    return 8'hfc;
            4'h1:    return 8'h60;
            4'h2:    return 8'hda;
            4'h3:    return 8'hf2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hb6;
            4'h6:    return 8'hbe;
            4'h7:    return 8'he0;
            4'h8:    return 8'hfe;
            4'h9:    return 8'hf6;
            4'ha:    return 8'hee;
            4'hb:    return 8'h3e;
            4'hc:    return 8'h9c;
            4'hd:    return 8'h7a;
            4'he:    return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s/%s expected %0h actual %0h", phase, name, expected, actual);
        end
    endtask

    // ----------------------------------------------------------
    // Reference model stepped on every rising edge
    // ----------------------------------------------------------

    always @(posedge slow_clk) begin
        if (rst) begin
            exp_valid    = '0;
            exp_result   = '0;
            pending.delete();
            scan_cnt     = 0;
            digit_idx    = 0;
            exp_segments = hex_segments(4'h0);
            exp_digit    = digit_sel_t'(1);
        end
        else begin
            // Display registers take the number and select from before the edge
            exp_segments = hex_segments(exp_result[digit_idx * 4 +: 4]);
            exp_digit    = digit_sel_t'(1) << digit_idx;
            if (scan_cnt == scan_period - 1) begin
                scan_cnt  = 0;
                digit_idx = (digit_idx + 1) % `POWER_W_DIGIT;
            end
            else begin
                scan_cnt++;
            end

            // Last stage loads when its input is valid
            if (exp_valid[3]) begin
                if (exp_valid[4]) begin
                    back_to_back++;
                end
                exp_result = pending.pop_front();
                results_seen++;
            end

            exp_valid = {exp_valid[3:0], key[0]};
            if (key[0]) begin
                pending.push_back(fifth_power(sw));
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge slow_clk) begin
        check_value("led", 64'({3'b000, exp_valid}), 64'(led));
        check_value("abcdefgh", 64'(exp_segments), 64'(abcdefgh));
        check_value("dot", 64'(0), 64'(abcdefgh[0]));
        check_value("digit", 64'(exp_digit), 64'(digit));
        check_value("digit one-hot", 64'(1), 64'($onehot(digit)));
    end

    // Run limit
    always @(posedge slow_clk) begin
        cycle_count++;
        if (cycle_count == limit_cycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    initial begin
        logic press;
        int   burst;

        slow_clk  = 1'b0;
        rst       = 1'b1;
        key       = '0;
        sw        = '0;
        lcg_state = 32'd76;
        burst     = 0;
        phase     = "reset";

        repeat (reset_cycles) @(posedge slow_clk);
        rst <= 1'b0;

        // Single strobe walking its valid flag through the LEDs
        phase = "valid_walk";
        @(posedge slow_clk);
        key <= 4'b0001;
        sw  <= 8'd3;
        @(posedge slow_clk);
        key <= 4'b0000;
        for (int i = 0; i < 5; i++) begin
            @(negedge slow_clk);
            check_value("walk led", 64'(8'(1) << i), 64'(led));
            @(posedge slow_clk);
        end

        // Random strobes and bursts
        phase = "random";
        for (int c = 0; c < stim_cycles - walk_cycles; c++) begin
            @(posedge slow_clk);
            lcg_state = lcg_next(lcg_state);
            press     = 1'b0;
            if (burst > 0) begin
                press = 1'b1;
                burst--;
            end
            else if (lcg_state[31:28] < 4'd3) begin
                press = 1'b1;
                burst = int'(lcg_state[26:24]) % 6;
            end
            key <= {3'b000, press};
            sw  <= lcg_state[23:16];
        end

        // Last result stays on the display without strobes
        phase = "hold";
        @(posedge slow_clk);
        key <= 4'b0000;
        repeat (hold_cycles) @(posedge slow_clk);
        @(negedge slow_clk);

        if (back_to_back == 0) begin
            errors++;
            $display("No results arrived on consecutive cycles");
        end

        $display("Run done after %0d cycles with %0d results and %0d errors",
                 cycle_count, results_seen, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
